/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_fub_wb_frontend
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_util.svh */
// included inside the testbench module; needs lfsr_state and abort_run declared there first
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

  // ------------------------------
  // random numbers
  // ------------------------------

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // n fresh bits, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // single compare point for every value check
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      abort_run();
    end
  endtask

`endif

/* bench/tb_fub_wb_frontend.sv */
// one random run from a fixed seed; model timing assumes the registered port and DIV_LATENCY
module tb_fub_wb_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD   = 4;
  localparam logic [31:0] SEED         = 32'h6037_4483;
  localparam int          NUM_CYCLES   = 3000;
  localparam int          DRAIN_CYCLES = 60;
  localparam int          MAX_WAIT     = 100;

  logic                  clk;
  logic                  reset;
  logic                  issue_valid;
  fub_pkg::fub_id_t      issue_unit;
  regfile_pkg::reg_idx_t issue_dest;
  logic                  io_delayed;
  logic                  io_req;
  regfile_pkg::reg_idx_t io_dest;
  logic                  io_cancel;
  logic                  issue_ready;
  logic                  io_ack;
  logic                  wb_we;
  regfile_pkg::reg_idx_t wb_dest;
  fub_pkg::wb_src_t      wb_src;

  logic [31:0] lfsr_state;

  // reference model
  // cycle counts posedges since reset release
  int                    cycle;
  int                    fxp_due_q[$];
  regfile_pkg::reg_idx_t fxp_dest_q[$];
  logic                  div_pending;
  int                    div_cycle;
  regfile_pkg::reg_idx_t div_dest;
  // io requester phase
  // 0 idle, 1 waiting ack, 2 acked, 3 released
  int                    io_phase;
  int                    io_wait;

  `include "tb_util.svh"

  fub_wb_frontend dut (
    .clk           (clk),
    .reset         (reset),
    .issue_valid_i (issue_valid),
    .issue_unit_i  (issue_unit),
    .issue_dest_i  (issue_dest),
    .io_delayed_i  (io_delayed),
    .io_req_i      (io_req),
    .io_dest_i     (io_dest),
    .io_cancel_i   (io_cancel),
    .issue_ready_o (issue_ready),
    .io_ack_o      (io_ack),
    .wb_we_o       (wb_we),
    .wb_dest_o     (wb_dest),
    .wb_src_o      (wb_src)
  );

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "stopped at cycle %0d", cycle);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // whole run plus margin
  initial begin
    #((NUM_CYCLES + DRAIN_CYCLES + 20) * CLK_PERIOD);
    $display("watchdog expired before the run finished");
    abort_run();
  end

  // ------------------------------
  // output checks at the negedge
  // ------------------------------

  task automatic check_outputs();
    logic exp_fxp;
    logic io_write;
    exp_fxp  = (fxp_due_q.size() > 0) && (fxp_due_q[0] == cycle);
    io_write = wb_we && (wb_src == fub_pkg::SRC_IO) && !exp_fxp;
    // fixed-point slot owns the port
    if (exp_fxp) begin
      check_value("fxp_we", 1, 32'(wb_we));
      check_value("fxp_src", 32'(fub_pkg::SRC_FIXEDPOINT), 32'(wb_src));
      check_value("fxp_dest", 32'(fxp_dest_q[0]), 32'(wb_dest));
      void'(fxp_due_q.pop_front());
      void'(fxp_dest_q.pop_front());
    end else if (wb_we && wb_src == fub_pkg::SRC_DIV) begin
      check_value("div_pending", 1, 32'(div_pending));
      check_value("div_latency", 1, 32'(cycle - div_cycle >= fub_pkg::DIV_LATENCY + 1));
      check_value("div_dest", 32'(div_dest), 32'(wb_dest));
      div_pending = 1'b0;
    end else if (wb_we && !io_write) begin
      $display("fixed-point write with no issue behind it");
      abort_run();
    end
    if (div_pending && cycle - div_cycle > MAX_WAIT) begin
      $display("divide result never reached the port");
      abort_run();
    end
    // handshake phases
    case (io_phase)
      1: begin
        if (io_cancel) begin
          check_value("io_cancel_ack", 1, 32'(io_ack));
          check_value("io_cancel_write", 0, 32'(io_write));
        end else begin
          // ack rises exactly with the write
          check_value("io_ack_write", 32'(io_write), 32'(io_ack));
          if (io_write) begin
            check_value("io_dest", 32'(io_dest), 32'(wb_dest));
          end
        end
        io_wait++;
        if (io_ack) begin
          io_phase = 2;
        end else if (io_wait > MAX_WAIT) begin
          $display("io request never acknowledged");
          abort_run();
        end
      end
      2: begin
        check_value("io_ack_hold", 1, 32'(io_ack));
        check_value("io_extra_write", 0, 32'(io_write));
      end
      3: begin
        check_value("io_ack_fall", 0, 32'(io_ack));
        check_value("io_extra_write", 0, 32'(io_write));
        io_phase = 0;
      end
      default: begin
        check_value("io_ack_idle", 0, 32'(io_ack));
        check_value("io_idle_write", 0, 32'(io_write));
      end
    endcase
  endtask

  // ------------------------------
  // stimulus and model update
  // ------------------------------

  task automatic drive_inputs(input logic active);
    logic [31:0] r;
    logic        ready_exp;
    r           = rand_bits(2);
    issue_unit  = fub_pkg::fub_id_t'(r[1:0]);
    issue_valid = active && (rand_bits(1) == 1);
    issue_dest  = regfile_pkg::reg_idx_t'(rand_bits(regfile_pkg::REG_IDX_W));
    io_delayed  = (rand_bits(2) == 0);
    // io unit side of the four-phase rule
    if (io_phase == 0 && active && rand_bits(2) == 0) begin
      io_dest   = regfile_pkg::reg_idx_t'(rand_bits(regfile_pkg::REG_IDX_W));
      io_cancel = (rand_bits(2) == 0);
      io_req    = 1'b1;
      io_phase  = 1;
      io_wait   = 0;
    end else if (io_phase == 2 && (!active || rand_bits(1) == 1)) begin
      io_req   = 1'b0;
      io_phase = 3;
    end
    case (issue_unit)
      fub_pkg::FUB_DIV: ready_exp = !div_pending;
      fub_pkg::FUB_IO:  ready_exp = !io_delayed;
      default:          ready_exp = 1'b1;
    endcase
    // readiness is combinational and needs a moment to settle
    #1;
    check_value("issue_ready", 32'(ready_exp), 32'(issue_ready));
    // accepted on the coming posedge at cycle + 1
    if (issue_valid && ready_exp) begin
      if (issue_unit == fub_pkg::FUB_FIXEDPOINT) begin
        fxp_due_q.push_back(cycle + 2);
        fxp_dest_q.push_back(issue_dest);
      end else if (issue_unit == fub_pkg::FUB_DIV) begin
        div_pending = 1'b1;
        div_cycle   = cycle + 1;
        div_dest    = issue_dest;
      end
    end
  endtask

  initial begin
    lfsr_state  = SEED;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_unit  = fub_pkg::FUB_NONE;
    issue_dest  = '0;
    io_delayed  = 1'b0;
    io_req      = 1'b0;
    io_dest     = '0;
    io_cancel   = 1'b0;
    cycle       = 0;
    div_pending = 1'b0;
    div_cycle   = 0;
    div_dest    = '0;
    io_phase    = 0;
    io_wait     = 0;
    // port and ack stay quiet through two reset cycles
    repeat (2) begin
      @(negedge clk);
      check_value("reset_we", 0, 32'(wb_we));
      check_value("reset_ack", 0, 32'(io_ack));
    end
    reset = 1'b0;
    drive_inputs(1'b1);
    for (int i = 1; i < NUM_CYCLES + DRAIN_CYCLES; i++) begin
      @(negedge clk);
      cycle++;
      check_outputs();
      drive_inputs(i < NUM_CYCLES);
    end
    // outstanding divide and io request must have landed
    check_value("drain_div", 0, 32'(div_pending));
    check_value("drain_io", 0, 32'(io_phase));
    $display("TB PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
hdl/regfile_pkg.sv
hdl/fub_pkg.sv
hdl/issue_dispatch.sv
hdl/div_manager.sv
hdl/io_wb_manager.sv
hdl/wb_port_arbiter.sv
hdl/fub_wb_frontend.sv
bench/tb_fub_wb_frontend.sv

/* hdl/div_manager.sv */
// one outstanding divide; the start strobe is only given while idle_o is high
module div_manager (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  div_start_i,
  input  regfile_pkg::reg_idx_t div_dest_i,
  input  logic                  grant_i,
  output logic                  idle_o,
  output logic                  req_o,
  output regfile_pkg::reg_idx_t dest_o
);

  // divide in flight, from start until its write is granted
  logic busy;

  // remaining latency cycles
  logic [fub_pkg::DIV_CTR_W-1:0] ctr;

  // pending destination
  regfile_pkg::reg_idx_t dest_q;

  // ------------------------------
  // latency countdown
  // ------------------------------

  // count reaches zero DIV_LATENCY edges after the start edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      ctr  <= '0;
    end else begin
      if (div_start_i) begin
        busy <= 1'b1;
        ctr  <= fub_pkg::DIV_CTR_W'(fub_pkg::DIV_LATENCY);
      end else begin
        if (ctr != '0) begin
          ctr <= ctr - 1'b1;
        end
        // write won the port, free again
        if (req_o && grant_i) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // payload, held until the write
  always_ff @(posedge clk) begin
    if (div_start_i) begin
      dest_q <= div_dest_i;
    end
  end

  // ------------------------------
  // port request
  // ------------------------------

  // keeps requesting while losing to higher priority sources
  assign req_o  = busy & (ctr == '0);
  assign dest_o = dest_q;
  assign idle_o = ~busy;

endmodule

/* hdl/fub_pkg.sv */
// unit ids, write-back source codes and latencies; DIV_LATENCY must be at least 1
package fub_pkg;

  // ------------------------------
  // issue targets
  // ------------------------------

  // unit an issued instruction is routed to
  // FUB_NONE is accepted and produces no write
  typedef enum logic [1:0] {
    FUB_FIXEDPOINT = 2'd0,
    FUB_DIV        = 2'd1,
    FUB_IO         = 2'd2,
    FUB_NONE       = 2'd3
  } fub_id_t;

  // ------------------------------
  // write-back sources
  // ------------------------------

  // tag driven on the gpr port with each write
  typedef enum logic [1:0] {
    SRC_FIXEDPOINT = 2'd0,
    SRC_DIV        = 2'd1,
    SRC_IO         = 2'd2
  } wb_src_t;

  // ------------------------------
  // latencies
  // ------------------------------

  // cycles from divide issue until its result may go to the port
  localparam int DIV_LATENCY = 6;

  // countdown must hold DIV_LATENCY itself
  localparam int DIV_CTR_W = $clog2(DIV_LATENCY + 1);

endpackage

/* hdl/fub_wb_frontend.sv */
// single gpr write-back port shared by fxp, div and io; io_delayed_i comes from the io unit
module fub_wb_frontend (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_valid_i,
  input  fub_pkg::fub_id_t      issue_unit_i,
  input  regfile_pkg::reg_idx_t issue_dest_i,
  input  logic                  io_delayed_i,
  input  logic                  io_req_i,
  input  regfile_pkg::reg_idx_t io_dest_i,
  input  logic                  io_cancel_i,
  output logic                  issue_ready_o,
  output logic                  io_ack_o,
  output logic                  wb_we_o,
  output regfile_pkg::reg_idx_t wb_dest_o,
  output fub_pkg::wb_src_t      wb_src_o
);

  // ------------------------------
  // internal wires
  // ------------------------------

  // dispatch to divider
  logic div_start;
  logic div_idle;

  // fixed-point write request
  logic                  fxp_req;
  regfile_pkg::reg_idx_t fxp_dest;

  // manager requests and grants
  logic                  div_req;
  regfile_pkg::reg_idx_t div_dest;
  logic                  div_grant;
  logic                  io_wb_req;
  regfile_pkg::reg_idx_t io_wb_dest;
  logic                  io_grant;

  // ------------------------------
  // submodules
  // ------------------------------

  issue_dispatch u_dispatch (
    .clk           (clk),
    .reset         (reset),
    .issue_valid_i (issue_valid_i),
    .issue_unit_i  (issue_unit_i),
    .issue_dest_i  (issue_dest_i),
    .div_idle_i    (div_idle),
    .io_delayed_i  (io_delayed_i),
    .issue_ready_o (issue_ready_o),
    .div_start_o   (div_start),
    .fxp_req_o     (fxp_req),
    .fxp_dest_o    (fxp_dest)
  );

  // dest taken straight from the issue bus on the start edge
  div_manager u_div (
    .clk         (clk),
    .reset       (reset),
    .div_start_i (div_start),
    .div_dest_i  (issue_dest_i),
    .grant_i     (div_grant),
    .idle_o      (div_idle),
    .req_o       (div_req),
    .dest_o      (div_dest)
  );

  io_wb_manager u_io (
    .clk         (clk),
    .reset       (reset),
    .io_req_i    (io_req_i),
    .io_dest_i   (io_dest_i),
    .io_cancel_i (io_cancel_i),
    .grant_i     (io_grant),
    .io_ack_o    (io_ack_o),
    .req_o       (io_wb_req),
    .dest_o      (io_wb_dest)
  );

  wb_port_arbiter u_arb (
    .clk         (clk),
    .reset       (reset),
    .fxp_req_i   (fxp_req),
    .fxp_dest_i  (fxp_dest),
    .io_req_i    (io_wb_req),
    .io_dest_i   (io_wb_dest),
    .div_req_i   (div_req),
    .div_dest_i  (div_dest),
    .io_grant_o  (io_grant),
    .div_grant_o (div_grant),
    .wb_we_o     (wb_we_o),
    .wb_dest_o   (wb_dest_o),
    .wb_src_o    (wb_src_o)
  );

endmodule

/* hdl/io_wb_manager.sv */
// four-phase req/ack; io_dest_i and io_cancel_i must stay stable while io_req_i is high
module io_wb_manager (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  io_req_i,
  input  regfile_pkg::reg_idx_t io_dest_i,
  input  logic                  io_cancel_i,
  input  logic                  grant_i,
  output logic                  io_ack_o,
  output logic                  req_o,
  output regfile_pkg::reg_idx_t dest_o
);

  // handshake phases
  typedef enum logic [1:0] {
    ST_WAIT = 2'd0,
    ST_REQ  = 2'd1,
    ST_ACK  = 2'd2
  } io_state_t;

  io_state_t state;
  io_state_t state_next;

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_WAIT: begin
        // cancelled requests skip the port entirely
        if (io_req_i) begin
          state_next = io_cancel_i ? ST_ACK : ST_REQ;
        end
      end
      ST_REQ: begin
        // ack rises together with the registered write
        if (grant_i) begin
          state_next = ST_ACK;
        end
      end
      ST_ACK: begin
        // hold ack until the requester lets go
        if (!io_req_i) begin
          state_next = ST_WAIT;
        end
      end
      default: state_next = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ST_WAIT;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  // ack straight from state, no glitches toward the io unit
  assign io_ack_o = (state == ST_ACK);

  // dest is held by the io unit, no local copy
  assign req_o  = (state == ST_REQ);
  assign dest_o = io_dest_i;

endmodule

/* hdl/issue_dispatch.sv */
// issue_ready_o is combinational; one issue per cycle, fixed-point writes need no back-pressure
module issue_dispatch (
  input  logic               clk,
  input  logic               reset,
  input  logic               issue_valid_i,
  input  fub_pkg::fub_id_t   issue_unit_i,
  input  regfile_pkg::reg_idx_t issue_dest_i,
  input  logic               div_idle_i,
  input  logic               io_delayed_i,
  output logic               issue_ready_o,
  output logic               div_start_o,
  output logic               fxp_req_o,
  output regfile_pkg::reg_idx_t fxp_dest_o
);

  // accepted issue this cycle
  logic accept;

  // ------------------------------
  // readiness per unit
  // ------------------------------

  always_comb begin
    // fixed-point and none never stall
    issue_ready_o = 1'b1;
    case (issue_unit_i)
      // one divide at a time
      fub_pkg::FUB_DIV: issue_ready_o = div_idle_i;
      // io unit busy with a delayed write
      fub_pkg::FUB_IO:  issue_ready_o = ~io_delayed_i;
      default:          issue_ready_o = 1'b1;
    endcase
  end

  assign accept = issue_valid_i & issue_ready_o;

  // one-cycle strobe, div manager captures the dest itself
  assign div_start_o = accept & (issue_unit_i == fub_pkg::FUB_DIV);

  // ------------------------------
  // fixed-point write request
  // ------------------------------

  // one stage, back-to-back issues give back-to-back requests
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fxp_req_o <= 1'b0;
    end else begin
      fxp_req_o <= accept & (issue_unit_i == fub_pkg::FUB_FIXEDPOINT);
    end
  end

  // dest only meaningful while fxp_req_o is high
  always_ff @(posedge clk) begin
    fxp_dest_o <= issue_dest_i;
  end

endmodule

/* hdl/regfile_pkg.sv */
// gpr shape only; a 32-entry register file with power-of-two count assumed by index width
package regfile_pkg;

  // ------------------------------
  // register file geometry
  // ------------------------------

  // number of general purpose registers
  localparam int REG_COUNT = 32;

  // index width follows the count
  localparam int REG_IDX_W = $clog2(REG_COUNT);

  // one register index, the payload of every write-back source
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

/* hdl/wb_port_arbiter.sv */
// fixed priority fxp > io > div; grants are combinational, the gpr port is registered
module wb_port_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fxp_req_i,
  input  regfile_pkg::reg_idx_t fxp_dest_i,
  input  logic                  io_req_i,
  input  regfile_pkg::reg_idx_t io_dest_i,
  input  logic                  div_req_i,
  input  regfile_pkg::reg_idx_t div_dest_i,
  output logic                  io_grant_o,
  output logic                  div_grant_o,
  output logic                  wb_we_o,
  output regfile_pkg::reg_idx_t wb_dest_o,
  output fub_pkg::wb_src_t      wb_src_o
);

  // ------------------------------
  // grants
  // ------------------------------

  // fixed-point always wins, so it needs no grant back
  assign io_grant_o  = io_req_i & ~fxp_req_i;
  assign div_grant_o = div_req_i & ~fxp_req_i & ~io_req_i;

  // ------------------------------
  // port register
  // ------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= fxp_req_i | io_req_i | div_req_i;
    end
  end

  // winner's payload, don't care when wb_we_o is low
  always_ff @(posedge clk) begin
    if (fxp_req_i) begin
      wb_dest_o <= fxp_dest_i;
      wb_src_o  <= fub_pkg::SRC_FIXEDPOINT;
    end else if (io_req_i) begin
      wb_dest_o <= io_dest_i;
      wb_src_o  <= fub_pkg::SRC_IO;
    end else begin
      wb_dest_o <= div_dest_i;
      wb_src_o  <= fub_pkg::SRC_DIV;
    end
  end

endmodule
